//--- bench/axi_id_remap_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module axi_id_remap_assertions (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  slv_aw_valid_i,
  input logic                  slv_aw_ready_o,
  input id_remap_pkg::mst_ax_t mst_aw_o,
  input logic                  mst_aw_valid_o,
  input logic                  mst_aw_ready_i,
  input logic                  slv_ar_valid_i,
  input logic                  slv_ar_ready_o,
  input id_remap_pkg::mst_ax_t mst_ar_o,
  input logic                  mst_ar_valid_o,
  input logic                  mst_ar_ready_i
);

  // Number of assertion failures seen so far.
  int unsigned fail_count = 0;

  // A stalled downstream request keeps valid high and its ID unchanged.
  aw_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o.id))
    else begin
      $error("AW valid or ID changed while stalled");
      fail_count++;
    end
  ar_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o.id))
    else begin
      $error("AR valid or ID changed while stalled");
      fail_count++;
    end

  // Nothing is buffered, so upstream and downstream handshakes happen together.
  aw_hs_mirror: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_aw_valid_i && slv_aw_ready_o) == (mst_aw_valid_o && mst_aw_ready_i))
    else begin
      $error("AW upstream and downstream handshakes differ");
      fail_count++;
    end
  ar_hs_mirror: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_ar_valid_i && slv_ar_ready_o) == (mst_ar_valid_o && mst_ar_ready_i))
    else begin
      $error("AR upstream and downstream handshakes differ");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/remap_checker.sv
`timescale 1ns/100ps
`default_nettype none

module remap_checker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  id_remap_pkg::slv_ax_t slv_aw_i,
  input  logic                  slv_aw_valid_i,
  input  logic                  slv_aw_ready_o,
  input  id_remap_pkg::mst_ax_t mst_aw_o,
  input  logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  input  id_remap_pkg::w_chan_t slv_w_i,
  input  logic                  slv_w_valid_i,
  input  logic                  slv_w_ready_o,
  input  id_remap_pkg::w_chan_t mst_w_o,
  input  logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  id_remap_pkg::slv_ax_t slv_ar_i,
  input  logic                  slv_ar_valid_i,
  input  logic                  slv_ar_ready_o,
  input  id_remap_pkg::mst_ax_t mst_ar_o,
  input  logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  id_remap_pkg::mst_b_t  mst_b_i,
  input  logic                  mst_b_valid_i,
  input  logic                  mst_b_ready_o,
  input  id_remap_pkg::slv_b_t  slv_b_o,
  input  logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  input  id_remap_pkg::mst_r_t  mst_r_i,
  input  logic                  mst_r_valid_i,
  input  logic                  mst_r_ready_o,
  input  id_remap_pkg::slv_r_t  slv_r_o,
  input  logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,
  input  id_remap_pkg::mst_id_t exp_aw_id_i,
  input  id_remap_pkg::mst_id_t exp_ar_id_i
);

  import id_remap_pkg::*;

  // Reference tables, index 0 for writes and 1 for reads.
  int unsigned model_id  [2][MAX_UNIQ_IDS];
  int unsigned model_cnt [2][MAX_UNIQ_IDS];
  int unsigned error_count = 0;

  task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
    error_count++;
    $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  // A live entry with the same ID wins, otherwise the lowest empty entry.
  task automatic lookup(input int d, input int unsigned id, output bit can, output int idx);
    int hit;
    int empty;
    hit = -1;
    empty = -1;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (model_cnt[d][i] != 0 && model_id[d][i] == id) hit = i;
      if (model_cnt[d][i] == 0) empty = i;
    end
    if (hit >= 0) begin
      idx = hit;
      can = model_cnt[d][hit] < MAX_TXNS_PER_ID;
    end else begin
      idx = (empty >= 0) ? empty : 0;
      can = (empty >= 0);
    end
  endtask

  // Checks one address channel and returns the index to push, or -1.
  task automatic check_addr(input int d, input slv_ax_t up, input logic up_vld, input logic up_rdy,
                            input mst_ax_t dn, input logic dn_vld, input logic dn_rdy,
                            input mst_id_t exp, output int push_idx);
    bit can;
    int idx;
    push_idx = -1;
    lookup(d, up.id, can, idx);
    if (up_vld && !dn_vld && can) begin
      error_count++;
      $display("Request with room in the table was not forwarded downstream");
    end
    if (dn_vld && !can) begin
      error_count++;
      $display("Request was forwarded although its table had no room");
    end
    if (dn_vld && dn_rdy) begin
      if (dn.id != mst_id_t'(idx)) report(d ? "mst_ar_o.id" : "mst_aw_o.id", dn.id, idx);
      if (dn.id != exp) report(d ? "mst_ar_o.id (table)" : "mst_aw_o.id (table)", dn.id, exp);
      if (dn.addr != up.addr) report(d ? "mst_ar_o.addr" : "mst_aw_o.addr", dn.addr, up.addr);
      if (dn.len != up.len) report(d ? "mst_ar_o.len" : "mst_aw_o.len", dn.len, up.len);
      if (!up_rdy) report(d ? "slv_ar_ready_o" : "slv_aw_ready_o", up_rdy, 1);
      push_idx = idx;
    end
  endtask

  // Write data, the response valids and the response readies are plain wires.
  task automatic check_passthrough();
    if (mst_w_o.data != slv_w_i.data) report("mst_w_o.data", mst_w_o.data, slv_w_i.data);
    if (mst_w_o.last != slv_w_i.last) report("mst_w_o.last", mst_w_o.last, slv_w_i.last);
    if (mst_w_valid_o != slv_w_valid_i) report("mst_w_valid_o", mst_w_valid_o, slv_w_valid_i);
    if (slv_w_ready_o != mst_w_ready_i) report("slv_w_ready_o", slv_w_ready_o, mst_w_ready_i);
    if (slv_b_valid_o != mst_b_valid_i) report("slv_b_valid_o", slv_b_valid_o, mst_b_valid_i);
    if (mst_b_ready_o != slv_b_ready_i) report("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i);
    if (slv_r_valid_o != mst_r_valid_i) report("slv_r_valid_o", slv_r_valid_o, mst_r_valid_i);
    if (mst_r_ready_o != slv_r_ready_i) report("mst_r_ready_o", mst_r_ready_o, slv_r_ready_i);
  endtask

  // Outputs are settled by the falling edge, and the table changes only
  // at the next rising edge, so every lookup here sees the current state.
  always @(negedge clk_i) begin
    int aw_push;
    int ar_push;
    int b_idx;
    int r_idx;
    if (reset_i) begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        model_cnt[0][i] = 0;
        model_cnt[1][i] = 0;
      end
    end else begin
      check_passthrough();
      check_addr(0, slv_aw_i, slv_aw_valid_i, slv_aw_ready_o, mst_aw_o, mst_aw_valid_o,
                 mst_aw_ready_i, exp_aw_id_i, aw_push);
      check_addr(1, slv_ar_i, slv_ar_valid_i, slv_ar_ready_o, mst_ar_o, mst_ar_valid_o,
                 mst_ar_ready_i, exp_ar_id_i, ar_push);
      b_idx = mst_b_i.id % MAX_UNIQ_IDS;
      r_idx = mst_r_i.id % MAX_UNIQ_IDS;
      if (mst_b_valid_i && slv_b_ready_i) begin
        if (model_cnt[0][b_idx] == 0) begin
          error_count++;
          $display("B response arrived for a write index with nothing in flight");
        end
        if (slv_b_o.id != model_id[0][b_idx]) report("slv_b_o.id", slv_b_o.id, model_id[0][b_idx]);
        if (slv_b_o.resp != mst_b_i.resp) report("slv_b_o.resp", slv_b_o.resp, mst_b_i.resp);
        model_cnt[0][b_idx]--;
      end
      if (mst_r_valid_i && slv_r_ready_i) begin
        if (model_cnt[1][r_idx] == 0) begin
          error_count++;
          $display("R beat arrived for a read index with nothing in flight");
        end
        if (slv_r_o.id != model_id[1][r_idx]) report("slv_r_o.id", slv_r_o.id, model_id[1][r_idx]);
        if (slv_r_o.data != mst_r_i.data) report("slv_r_o.data", slv_r_o.data, mst_r_i.data);
        if (slv_r_o.resp != mst_r_i.resp) report("slv_r_o.resp", slv_r_o.resp, mst_r_i.resp);
        if (slv_r_o.last != mst_r_i.last) report("slv_r_o.last", slv_r_o.last, mst_r_i.last);
        // Only the closing beat of a burst frees its slot.
        if (mst_r_i.last) model_cnt[1][r_idx]--;
      end
      if (aw_push >= 0) begin
        model_id[0][aw_push] = slv_aw_i.id;
        model_cnt[0][aw_push]++;
      end
      if (ar_push >= 0) begin
        model_id[1][ar_push] = slv_ar_i.id;
        model_cnt[1][ar_push]++;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_axi_id_remap.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_id_remap;

  import id_remap_pkg::*;

  localparam int TIMEOUT = 50;
  localparam int NUM_ROWS = 13;

  // One request per row: direction, upstream ID, cycles with downstream ready
  // low, responses to finish first, whether it must wait for room, and the
  // downstream ID the tables should hand out.
  typedef struct packed {
    logic       rd;
    slv_id_t    id;
    logic [3:0] stall;
    logic [1:0] pops;
    logic       blocked;
    mst_id_t    exp;
  } row_t;

  logic clk_i = 1'b0;
  logic reset_i;
  slv_ax_t slv_aw_i, slv_ar_i;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  w_chan_t slv_w_i, mst_w_o;
  logic slv_w_valid_i, slv_w_ready_o, mst_w_valid_o, mst_w_ready_i;
  slv_b_t slv_b_o;
  logic slv_b_valid_o, slv_b_ready_i;
  slv_r_t slv_r_o;
  logic slv_r_valid_o, slv_r_ready_i;
  mst_ax_t mst_aw_o, mst_ar_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  mst_b_t mst_b_i;
  logic mst_b_valid_i, mst_b_ready_o;
  mst_r_t mst_r_i;
  logic mst_r_valid_i, mst_r_ready_o;
  mst_id_t exp_aw_id, exp_ar_id;

  row_t    rows [NUM_ROWS];
  mst_id_t wr_pending [$];
  mst_id_t rd_pending [$];
  logic [31:0] rng_state = 32'd88;
  int unsigned timeouts = 0;

  always #5 clk_i = ~clk_i;

  axi_id_remap u_dut (.*);

  remap_checker u_chk (.*, .exp_aw_id_i(exp_aw_id), .exp_ar_id_i(exp_ar_id));

  bind axi_id_remap axi_id_remap_assertions u_assert (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Waits at falling edges until the current response beat is taken.
  task automatic wait_response(input logic rd);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!(rd ? (slv_r_valid_o && slv_r_ready_i) : (slv_b_valid_o && slv_b_ready_i))) begin
      cyc++;
      if (cyc > TIMEOUT) begin
        timeouts++;
        $display("Timed out waiting for a %s response handshake", rd ? "read" : "write");
        return;
      end
      @(negedge clk_i);
    end
  endtask

  // The responder answers the oldest issued ID of one direction.
  // Reads are two-beat bursts with pseudo-random data.
  // The upstream side holds off every beat for one cycle.
  task automatic respond(input logic rd);
    mst_id_t id;
    if (rd) begin
      id = rd_pending.pop_front();
      for (int beat = 0; beat < 2; beat++) begin
        rng_state = xorshift(rng_state);
        @(posedge clk_i);
        mst_r_i       <= '{id: id, data: rng_state, resp: rng_state[1:0], last: beat == 1};
        mst_r_valid_i <= 1'b1;
        slv_r_ready_i <= 1'b0;
        @(posedge clk_i);
        slv_r_ready_i <= 1'b1;
        wait_response(1'b1);
      end
      @(posedge clk_i);
      mst_r_valid_i <= 1'b0;
    end else begin
      id = wr_pending.pop_front();
      rng_state = xorshift(rng_state);
      @(posedge clk_i);
      mst_b_i       <= '{id: id, resp: rng_state[1:0]};
      mst_b_valid_i <= 1'b1;
      slv_b_ready_i <= 1'b0;
      @(posedge clk_i);
      slv_b_ready_i <= 1'b1;
      wait_response(1'b0);
      @(posedge clk_i);
      mst_b_valid_i <= 1'b0;
    end
  endtask

  // Sends the single data beat of a write after its address.
  // Downstream ready is low for the first cycle of the beat.
  task automatic send_write_data();
    int cyc;
    rng_state = xorshift(rng_state);
    @(posedge clk_i);
    slv_w_i       <= '{data: rng_state, last: 1'b1};
    slv_w_valid_i <= 1'b1;
    mst_w_ready_i <= 1'b0;
    @(posedge clk_i);
    mst_w_ready_i <= 1'b1;
    cyc = 0;
    @(negedge clk_i);
    while (!(mst_w_valid_o && mst_w_ready_i)) begin
      cyc++;
      if (cyc > TIMEOUT) begin
        timeouts++;
        $display("Timed out waiting for a write data handshake");
        break;
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    slv_w_valid_i <= 1'b0;
  endtask

  // Offers one address request and waits for it to be taken.
  task automatic issue_request(input row_t r, input int n);
    int cyc;
    bit done;
    for (int p = 0; p < r.pops; p++) respond(r.rd);
    @(posedge clk_i);
    if (r.rd) begin
      slv_ar_i       <= '{id: r.id, addr: 32'h2000 + n * 16, len: 8'd1};
      slv_ar_valid_i <= 1'b1;
      mst_ar_ready_i <= (r.stall == 0);
      exp_ar_id      <= r.exp;
    end else begin
      slv_aw_i       <= '{id: r.id, addr: 32'h1000 + n * 16, len: 8'd0};
      slv_aw_valid_i <= 1'b1;
      mst_aw_ready_i <= (r.stall == 0);
      exp_aw_id      <= r.exp;
    end
    // A request without room sits for a while, then one response frees room.
    if (r.blocked) begin
      repeat (4) @(posedge clk_i);
      respond(r.rd);
    end
    cyc = 0;
    done = 0;
    while (!done) begin
      @(negedge clk_i);
      if (r.rd ? slv_ar_ready_o : slv_aw_ready_o) begin
        if (r.rd) rd_pending.push_back(mst_ar_o.id);
        else wr_pending.push_back(mst_aw_o.id);
        done = 1;
      end
      @(posedge clk_i);
      cyc++;
      if (!done && cyc > TIMEOUT) begin
        timeouts++;
        $display("Timed out waiting for address request %0d to be accepted", n);
        done = 1;
      end
      if (done) begin
        slv_aw_valid_i <= 1'b0;
        slv_ar_valid_i <= 1'b0;
        mst_aw_ready_i <= 1'b0;
        mst_ar_ready_i <= 1'b0;
      end else if (cyc >= r.stall) begin
        mst_aw_ready_i <= 1'b1;
        mst_ar_ready_i <= 1'b1;
      end
    end
  endtask

  initial begin
    rows[0]  = '{rd: 0, id: 8'h5A, stall: 0, pops: 0, blocked: 0, exp: 4'h0};
    rows[1]  = '{rd: 0, id: 8'hC3, stall: 0, pops: 0, blocked: 0, exp: 4'h1};
    rows[2]  = '{rd: 0, id: 8'h5A, stall: 3, pops: 0, blocked: 0, exp: 4'h0};
    rows[3]  = '{rd: 0, id: 8'h5A, stall: 0, pops: 0, blocked: 0, exp: 4'h0};
    // Fourth outstanding 0x5A waits until its oldest write completes.
    rows[4]  = '{rd: 0, id: 8'h5A, stall: 0, pops: 0, blocked: 1, exp: 4'h0};
    rows[5]  = '{rd: 0, id: 8'h11, stall: 0, pops: 0, blocked: 0, exp: 4'h2};
    rows[6]  = '{rd: 0, id: 8'h22, stall: 0, pops: 0, blocked: 0, exp: 4'h3};
    // Fifth distinct ID takes the index freed by 0xC3.
    rows[7]  = '{rd: 0, id: 8'h33, stall: 0, pops: 0, blocked: 1, exp: 4'h1};
    rows[8]  = '{rd: 1, id: 8'h5A, stall: 0, pops: 0, blocked: 0, exp: 4'h0};
    rows[9]  = '{rd: 1, id: 8'hC3, stall: 2, pops: 0, blocked: 0, exp: 4'h1};
    rows[10] = '{rd: 1, id: 8'h33, stall: 0, pops: 0, blocked: 0, exp: 4'h2};
    rows[11] = '{rd: 1, id: 8'h44, stall: 0, pops: 1, blocked: 0, exp: 4'h0};
    rows[12] = '{rd: 1, id: 8'h44, stall: 1, pops: 0, blocked: 0, exp: 4'h0};
    reset_i        <= 1'b1;
    slv_aw_i       <= '0;
    slv_aw_valid_i <= 1'b0;
    slv_ar_i       <= '0;
    slv_ar_valid_i <= 1'b0;
    slv_w_i        <= '0;
    slv_w_valid_i  <= 1'b0;
    slv_b_ready_i  <= 1'b1;
    slv_r_ready_i  <= 1'b1;
    mst_aw_ready_i <= 1'b0;
    mst_ar_ready_i <= 1'b0;
    mst_w_ready_i  <= 1'b1;
    mst_b_i        <= '0;
    mst_b_valid_i  <= 1'b0;
    mst_r_i        <= '0;
    mst_r_valid_i  <= 1'b0;
    exp_aw_id      <= '0;
    exp_ar_id      <= '0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int n = 0; n < NUM_ROWS; n++) begin
      issue_request(rows[n], n);
      // Each write carries one data beat after its address.
      if (!rows[n].rd) send_write_data();
    end
    // Drain everything still in flight, oldest first.
    while (wr_pending.size() > 0) respond(1'b0);
    while (rd_pending.size() > 0) respond(1'b1);
    repeat (4) @(posedge clk_i);
    $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
             u_chk.error_count, u_dut.u_assert.fail_count, timeouts);
    if (u_chk.error_count == 0 && u_dut.u_assert.fail_count == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/id_remap_pkg.sv
src/remap_table.sv
src/ax_issue.sv
src/axi_id_remap.sv
bench/remap_checker.sv
bench/axi_id_remap_assertions.sv
bench/tb_axi_id_remap.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_axi_id_remap \
  -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1

grep -q "All tests passed" sim.log && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }

//--- src/ax_issue.sv
`timescale 1ns/100ps
`default_nettype none

module ax_issue (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               slv_valid_i,
  output logic               slv_ready_o,
  output logic               mst_valid_o,
  input  logic               mst_ready_i,
  input  logic               can_push_i,
  input  id_remap_pkg::idx_t grant_idx_i,
  output logic               push_o,
  output id_remap_pkg::idx_t mst_idx_o
);

  import id_remap_pkg::*;

  issue_state_e state_q;
  issue_state_e state_d;

  // Index of a request that was pushed but not yet taken downstream.
  idx_t held_idx_q;
  logic hold_capture;

  always_comb begin
    state_d     = state_q;
    mst_valid_o = 1'b0;
    push_o      = 1'b0;
    mst_idx_o   = grant_idx_i;

    case (state_q)
      ISSUE_READY: begin
        // A request is only forwarded when the table has room for it.
        // The push happens now, even if the downstream stalls, so the
        // table already counts this transaction while it waits.
        if (slv_valid_i && can_push_i) begin
          mst_valid_o = 1'b1;
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            state_d = ISSUE_HOLD;
          end
        end
      end

      ISSUE_HOLD: begin
        // The entry is already pushed, so only valid and the index are held.
        // The held index keeps the downstream ID stable even if pops
        // change what the table would grant now.
        mst_valid_o = 1'b1;
        mst_idx_o   = held_idx_q;
        if (mst_ready_i) begin
          state_d = ISSUE_READY;
        end
      end

      default: begin
        state_d = ISSUE_READY;
      end
    endcase
  end

  // Upstream sees the downstream ready, but only for a forwarded request.
  // A request the table cannot take is left waiting with ready low.
  assign slv_ready_o = mst_valid_o && mst_ready_i;

  // Capture the granted index on the cycle the machine enters the hold state.
  assign hold_capture = (state_q == ISSUE_READY) && push_o && !mst_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ISSUE_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // The index is payload and is only read in the hold state.
  always_ff @(posedge clk_i) begin
    if (hold_capture) begin
      held_idx_q <= grant_idx_i;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_id_remap.sv
`timescale 1ns/100ps
`default_nettype none

module axi_id_remap (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Upstream side with wide IDs.
  input  id_remap_pkg::slv_ax_t slv_aw_i,
  input  logic                  slv_aw_valid_i,
  output logic                  slv_aw_ready_o,
  input  id_remap_pkg::w_chan_t slv_w_i,
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  output id_remap_pkg::slv_b_t  slv_b_o,
  output logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  input  id_remap_pkg::slv_ax_t slv_ar_i,
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  output id_remap_pkg::slv_r_t  slv_r_o,
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,

  // Downstream side with narrow IDs.
  output id_remap_pkg::mst_ax_t mst_aw_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output id_remap_pkg::w_chan_t mst_w_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  id_remap_pkg::mst_b_t  mst_b_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  output id_remap_pkg::mst_ax_t mst_ar_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  id_remap_pkg::mst_r_t  mst_r_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o
);

  import id_remap_pkg::*;

  // Write direction between table and issue unit.
  logic    aw_can_push;
  idx_t    aw_grant_idx;
  logic    aw_push;
  idx_t    aw_idx;
  logic    wr_pop;
  slv_id_t wr_pop_id;

  // Read direction between table and issue unit.
  logic    ar_can_push;
  idx_t    ar_grant_idx;
  logic    ar_push;
  idx_t    ar_idx;
  logic    rd_pop;
  slv_id_t rd_pop_id;

  // A write completes with its B handshake.
  // A read completes only with the R beat that carries last.
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

  remap_table u_wr_table (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_id_i  (slv_aw_i.id),
    .can_push_o   (aw_can_push),
    .grant_idx_o  (aw_grant_idx),
    .push_i       (aw_push),
    .pop_i        (wr_pop),
    .pop_idx_i    (mst_b_i.id[IDX_W-1:0]),
    .pop_inp_id_o (wr_pop_id)
  );

  remap_table u_rd_table (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_id_i  (slv_ar_i.id),
    .can_push_o   (ar_can_push),
    .grant_idx_o  (ar_grant_idx),
    .push_i       (ar_push),
    .pop_i        (rd_pop),
    .pop_idx_i    (mst_r_i.id[IDX_W-1:0]),
    .pop_inp_id_o (rd_pop_id)
  );

  ax_issue u_aw_issue (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_valid_i (slv_aw_valid_i),
    .slv_ready_o (slv_aw_ready_o),
    .mst_valid_o (mst_aw_valid_o),
    .mst_ready_i (mst_aw_ready_i),
    .can_push_i  (aw_can_push),
    .grant_idx_i (aw_grant_idx),
    .push_o      (aw_push),
    .mst_idx_o   (aw_idx)
  );

  ax_issue u_ar_issue (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_valid_i (slv_ar_valid_i),
    .slv_ready_o (slv_ar_ready_o),
    .mst_valid_o (mst_ar_valid_o),
    .mst_ready_i (mst_ar_ready_i),
    .can_push_i  (ar_can_push),
    .grant_idx_i (ar_grant_idx),
    .push_o      (ar_push),
    .mst_idx_o   (ar_idx)
  );

  // The table index becomes the downstream ID, padded with zeros on top.
  assign mst_aw_o.id   = {{(MST_ID_W - IDX_W){1'b0}}, aw_idx};
  assign mst_aw_o.addr = slv_aw_i.addr;
  assign mst_aw_o.len  = slv_aw_i.len;

  assign mst_ar_o.id   = {{(MST_ID_W - IDX_W){1'b0}}, ar_idx};
  assign mst_ar_o.addr = slv_ar_i.addr;
  assign mst_ar_o.len  = slv_ar_i.len;

  // Write data has no ID and passes straight through.
  assign mst_w_o       = slv_w_i;
  assign mst_w_valid_o = slv_w_valid_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Responses get their upstream ID back from the table.
  assign slv_b_o.id    = wr_pop_id;
  assign slv_b_o.resp  = mst_b_i.resp;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

  // Every R beat is translated, not only the last one.
  assign slv_r_o.id    = rd_pop_id;
  assign slv_r_o.data  = mst_r_i.data;
  assign slv_r_o.resp  = mst_r_i.resp;
  assign slv_r_o.last  = mst_r_i.last;
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

endmodule

`default_nettype wire

//--- src/id_remap_pkg.sv
`default_nettype none

package id_remap_pkg;

  // Upstream IDs are wide and sparse, downstream IDs are narrow and dense.
  localparam int unsigned SLV_ID_W = 8;
  localparam int unsigned MST_ID_W = 4;

  // Each direction tracks this many distinct upstream IDs at once.
  localparam int unsigned MAX_UNIQ_IDS = 4;
  localparam int unsigned IDX_W = 2;

  // The counter must be able to hold the per-ID limit itself.
  localparam int unsigned MAX_TXNS_PER_ID = 3;
  localparam int unsigned CNT_W = 2;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned LEN_W = 8;

  typedef logic [SLV_ID_W-1:0]     slv_id_t;
  typedef logic [MST_ID_W-1:0]     mst_id_t;
  typedef logic [IDX_W-1:0]        idx_t;
  typedef logic [MAX_UNIQ_IDS-1:0] field_t;
  typedef logic [CNT_W-1:0]        cnt_t;
  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [LEN_W-1:0]        len_t;
  typedef logic [1:0]              resp_t;

  // Address request as seen on the upstream side.
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ax_t;

  // Address request after the ID has been remapped.
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ax_t;

  // Write data carries no ID, so one type serves both sides.
  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  // An address channel either forwards a fresh request or holds a stalled one.
  typedef enum logic {
    ISSUE_READY,
    ISSUE_HOLD
  } issue_state_e;

  // Returns the position of the lowest set bit.
  // An all-zero field gives index zero, so callers must check for that case.
  function automatic idx_t lowest_set_idx(input field_t field);
    idx_t idx;
    idx = '0;
    // Scanning from the top lets the lowest set bit be the last one written.
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (field[i]) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- src/remap_table.sv
`timescale 1ns/100ps
`default_nettype none

module remap_table (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  id_remap_pkg::slv_id_t lookup_id_i,
  output logic                  can_push_o,
  output id_remap_pkg::idx_t    grant_idx_o,
  input  logic                  push_i,
  input  logic                  pop_i,
  input  id_remap_pkg::idx_t    pop_idx_i,
  output id_remap_pkg::slv_id_t pop_inp_id_o
);

  import id_remap_pkg::*;

  // The table is indexed by the downstream index.
  // Each entry keeps the upstream ID that owns it and the number of
  // transactions still in flight under that ID.
  slv_id_t inp_id_q [MAX_UNIQ_IDS];
  cnt_t    [MAX_UNIQ_IDS-1:0] cnt_q;

  // One bit per entry for a matching ID and for an unused entry.
  field_t match;
  field_t free;

  idx_t match_idx;
  idx_t free_idx;
  logic exists;
  logic exists_full;

  // Per-entry update strobes.
  field_t inc;
  field_t dec;

  // An entry with a zero count is free, whatever ID it still stores.
  // A match needs a live entry, so stale IDs are never reused by accident.
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      free[i]  = (cnt_q[i] == '0);
      match[i] = (cnt_q[i] != '0) && (inp_id_q[i] == lookup_id_i);
    end
  end

  // Only one entry can match, because a push never creates a second live
  // entry for an ID that already has one.
  assign match_idx = lowest_set_idx(match);
  assign free_idx  = lowest_set_idx(free);
  assign exists    = |match;

  // The ID has reached its limit when its counter equals the maximum.
  assign exists_full = (cnt_q[match_idx] == cnt_t'(MAX_TXNS_PER_ID));

  // A known ID keeps its index so that ordering within the ID is kept.
  // A new ID takes the lowest free index.
  assign grant_idx_o = exists ? match_idx : free_idx;

  // A request is accepted if its ID has room or a fresh entry is available.
  assign can_push_o = exists ? !exists_full : |free;

  // The response path reads the owner of the index back out.
  assign pop_inp_id_o = inp_id_q[pop_idx_i];

  // Decode push and pop into per-entry increments and decrements.
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      inc[i] = push_i && (grant_idx_o == idx_t'(i));
      dec[i] = pop_i && (pop_idx_i == idx_t'(i));
    end
  end

  // Counters are control state and are cleared on reset.
  // A push and a pop on the same entry in one cycle cancel out.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // The stored ID only matters while the count is non-zero.
  // Rewriting the same ID on a repeated push is harmless.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      inp_id_q[grant_idx_o] <= lookup_id_i;
    end
  end

endmodule

`default_nettype wire
